// ==== hdl/stream_dispatch_pkg.sv ====
// stream dispatch package: word and block widths, header layout and kernel codes
package stream_dispatch_pkg;

    // stream and block geometry
    localparam int word_w          = 32;
    localparam int block_w         = 128;
    localparam int words_per_block = block_w / word_w;

    typedef logic [word_w-1:0]  word_t;
    typedef logic [block_w-1:0] block_t;

    // header field types
    typedef logic [7:0]  dst_t;
    typedef logic [7:0]  mode_t;
    typedef logic [15:0] len_t;

    // matches the header word: dst 31:24, mode 23:16, block count 15:0
    typedef struct packed {
        dst_t  dst;
        mode_t mode;
        len_t  len;
    } frame_hdr_t;

    // kernel 0 sits at this destination, the rest follow upward
    localparam dst_t kernel_dst_base = 8'h04;

    // transform modes understood by the kernels
    localparam mode_t mode_fft  = 8'd1;
    localparam mode_t mode_ifft = 8'd2;
    localparam mode_t mode_ntt  = 8'd3;
    localparam mode_t mode_intt = 8'd4;

    // legal block count is 1 .. max_blocks
    localparam int max_blocks = 256;

    localparam int num_kernels_def = 4;

endpackage

// ==== hdl/block_stream_if.sv ====
// block stream bundle: valid/ready handshake with data and frame-last flag
`timescale 1ns/1ps

interface block_stream_if #(
    parameter int width = stream_dispatch_pkg::block_w
) ();

    logic             vld;
    logic             rdy;
    logic [width-1:0] dat;
    // high on the final block of a frame
    logic             lst;

    modport source (
        output vld, dat, lst,
        input  rdy
    );

    modport sink (
        input  vld, dat, lst,
        output rdy
    );

endinterface

// ==== hdl/frame_ingress.sv ====
// frame ingress: decodes frame headers and packs payload words into kernel blocks
`timescale 1ns/1ps

module frame_ingress #(
    parameter int num_kernels = stream_dispatch_pkg::num_kernels_def,
    localparam int sel_w = (num_kernels > 1) ? $clog2(num_kernels) : 1
) (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            ss_vld,
    input  stream_dispatch_pkg::word_t      ss_dat,
    output logic                            ss_rdy,
    output logic                            hdr_stb,
    output stream_dispatch_pkg::frame_hdr_t hdr,
    output logic [sel_w-1:0]                kernel_sel,
    block_stream_if.source                  blk
);
    import stream_dispatch_pkg::*;

    localparam int lane_w    = $clog2(words_per_block);
    localparam int last_lane = words_per_block - 1;

    typedef enum logic [1:0] {
        st_hdr,
        st_pay,
        st_disc
    } state_t;

    state_t            state;
    frame_hdr_t        new_hdr;
    logic              dst_hit;
    logic              len_ok;
    logic              word_acc;
    len_t              blk_left;
    logic [lane_w-1:0] lane;
    block_t            pack_q;
    logic              pack_vld;
    logic              pack_lst;
    logic              hdr_stb_q;
    frame_hdr_t        hdr_q;
    logic [sel_w-1:0]  sel_q;

    assign new_hdr = frame_hdr_t'(ss_dat);

    // destination must name one of the fitted kernels
    assign dst_hit = (new_hdr.dst >= kernel_dst_base) &&
                     (new_hdr.dst < kernel_dst_base + num_kernels);
    assign len_ok  = (new_hdr.len <= max_blocks);

    // back-pressure while a packed block is still waiting
    assign ss_rdy   = !pack_vld;
    assign word_acc = ss_vld && ss_rdy;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= st_hdr;
            blk_left  <= '0;
            lane      <= '0;
            pack_vld  <= 1'b0;
            pack_lst  <= 1'b0;
            hdr_stb_q <= 1'b0;
        end else begin
            hdr_stb_q <= 1'b0;
            case (state)
                st_hdr: begin
                    // zero-length header carries no payload
                    if (word_acc && new_hdr.len != '0) begin
                        blk_left <= new_hdr.len;
                        lane     <= '0;
                        if (dst_hit && len_ok) begin
                            hdr_stb_q <= 1'b1;
                            state     <= st_pay;
                        end else begin
                            state <= st_disc;
                        end
                    end
                end
                st_pay: begin
                    if (pack_vld) begin
                        if (blk.rdy) begin
                            pack_vld <= 1'b0;
                            if (pack_lst) begin
                                state <= st_hdr;
                            end
                        end
                    end else if (word_acc) begin
                        lane <= lane + 1'b1;
                        if (lane == last_lane) begin
                            pack_vld <= 1'b1;
                            pack_lst <= (blk_left == 16'd1);
                            blk_left <= blk_left - 1'b1;
                        end
                    end
                end
                st_disc: begin
                    // swallow words at full rate
                    if (word_acc) begin
                        lane <= lane + 1'b1;
                        if (lane == last_lane) begin
                            blk_left <= blk_left - 1'b1;
                            if (blk_left == 16'd1) begin
                                state <= st_hdr;
                            end
                        end
                    end
                end
                default: state <= st_hdr;
            endcase
        end
    end

    // header copy and packing shift register
    always_ff @(posedge clk) begin
        if (state == st_hdr && word_acc) begin
            hdr_q <= new_hdr;
            sel_q <= sel_w'(new_hdr.dst - kernel_dst_base);
        end
        // first word ends up in the top lane
        if (state == st_pay && word_acc) begin
            pack_q <= {pack_q[block_w-word_w-1:0], ss_dat};
        end
    end

    assign blk.vld    = pack_vld;
    assign blk.dat    = pack_q;
    assign blk.lst    = pack_lst;
    assign hdr_stb    = hdr_stb_q;
    assign hdr        = hdr_q;
    assign kernel_sel = sel_q;

endmodule

// ==== hdl/kernel_router.sv ====
// kernel router: steers blocks to the selected kernel and issues decode and mode
`timescale 1ns/1ps

module kernel_router #(
    parameter int num_kernels = stream_dispatch_pkg::num_kernels_def,
    localparam int sel_w = (num_kernels > 1) ? $clog2(num_kernels) : 1
) (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            hdr_stb,
    input  stream_dispatch_pkg::frame_hdr_t hdr,
    input  logic [sel_w-1:0]                kernel_sel,
    input  logic [num_kernels-1:0]          k_ld_rdy,
    output logic [num_kernels-1:0]          k_ld_vld,
    output stream_dispatch_pkg::block_t     k_ld_dat,
    output logic [num_kernels-1:0]          k_decode,
    output stream_dispatch_pkg::mode_t      k_mode [num_kernels],
    block_stream_if.sink                    blk
);
    import stream_dispatch_pkg::*;

    logic [sel_w-1:0] sel_q;
    // set by decode, cleared once the last block is loaded
    logic             act_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            sel_q    <= '0;
            act_q    <= 1'b0;
            k_decode <= '0;
            for (int i = 0; i < num_kernels; i++) begin
                k_mode[i] <= '0;
            end
        end else begin
            if (hdr_stb) begin
                sel_q <= kernel_sel;
                act_q <= 1'b1;
            end else if (blk.vld && blk.rdy && blk.lst) begin
                act_q <= 1'b0;
            end
            // decode pulse and mode latch land on the same edge
            for (int i = 0; i < num_kernels; i++) begin
                k_decode[i] <= hdr_stb && (kernel_sel == sel_w'(i));
                if (hdr_stb && kernel_sel == sel_w'(i)) begin
                    k_mode[i] <= hdr.mode;
                end
            end
        end
    end

    // zero-cycle block path
    always_comb begin
        for (int i = 0; i < num_kernels; i++) begin
            k_ld_vld[i] = act_q && blk.vld && (sel_q == sel_w'(i));
        end
    end

    assign blk.rdy  = act_q && k_ld_rdy[sel_q];
    assign k_ld_dat = blk.dat;

endmodule

// ==== hdl/kernel_status.sv ====
// kernel status: per-kernel idle and done flags packed into the status word
`timescale 1ns/1ps

module kernel_status #(
    parameter int num_kernels = stream_dispatch_pkg::num_kernels_def
) (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic [num_kernels-1:0]   k_decode,
    input  logic [num_kernels-1:0]   frame_done,
    input  logic                     ap_read,
    output logic [2*num_kernels-1:0] ap_ctrl
);

    logic [num_kernels-1:0] idle_q;
    logic [num_kernels-1:0] done_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            idle_q <= '1;
            done_q <= '0;
        end else begin
            for (int i = 0; i < num_kernels; i++) begin
                // a new frame keeps the kernel busy even if the old one just left
                if (k_decode[i]) begin
                    idle_q[i] <= 1'b0;
                end else if (frame_done[i]) begin
                    idle_q[i] <= 1'b1;
                end
                // completion beats the read-clear
                if (frame_done[i]) begin
                    done_q[i] <= 1'b1;
                end else if (ap_read) begin
                    done_q[i] <= 1'b0;
                end
            end
        end
    end

    // kernel i: idle at 2i+1, done at 2i
    always_comb begin
        for (int i = 0; i < num_kernels; i++) begin
            ap_ctrl[2*i+1] = idle_q[i];
            ap_ctrl[2*i]   = done_q[i];
        end
    end

endmodule

// ==== hdl/result_serializer.sv ====
// result serializer: frame-locked arbitration of kernel results onto the word stream
`timescale 1ns/1ps

module result_serializer #(
    parameter int num_kernels = stream_dispatch_pkg::num_kernels_def
) (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic [num_kernels-1:0]      k_sw_vld,
    input  stream_dispatch_pkg::block_t k_sw_dat [num_kernels],
    input  logic [num_kernels-1:0]      k_sw_lst,
    output logic [num_kernels-1:0]      k_sw_rdy,
    input  logic                        sm_rdy,
    output logic                        sm_vld,
    output stream_dispatch_pkg::word_t  sm_dat,
    output logic                        sm_lst,
    output logic [num_kernels-1:0]      frame_done
);
    import stream_dispatch_pkg::*;

    localparam int idx_w     = (num_kernels > 1) ? $clog2(num_kernels) : 1;
    localparam int lane_w    = $clog2(words_per_block);
    localparam int last_lane = words_per_block - 1;

    logic [idx_w-1:0]  pick;
    logic [idx_w-1:0]  gnt;
    logic [idx_w-1:0]  gnt_q;
    logic              lock_q;
    logic              can_take;
    logic              take;
    block_t            shift_q;
    logic              out_vld;
    logic              out_lst;
    logic [lane_w-1:0] lane;

    // lowest index with a result waiting
    always_comb begin
        pick = '0;
        for (int i = num_kernels - 1; i >= 0; i--) begin
            if (k_sw_vld[i]) begin
                pick = idx_w'(i);
            end
        end
    end

    // grant stays put until the frame's last block
    assign gnt = lock_q ? gnt_q : pick;

    // room when empty or when the last word leaves this cycle
    assign can_take = !out_vld || (sm_rdy && lane == last_lane);

    always_comb begin
        for (int i = 0; i < num_kernels; i++) begin
            k_sw_rdy[i] = can_take && k_sw_vld[i] && (gnt == idx_w'(i));
        end
    end

    assign take       = |k_sw_rdy;
    assign frame_done = k_sw_rdy & k_sw_lst;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            gnt_q   <= '0;
            lock_q  <= 1'b0;
            out_vld <= 1'b0;
            out_lst <= 1'b0;
            lane    <= '0;
        end else if (take) begin
            gnt_q   <= gnt;
            lock_q  <= !k_sw_lst[gnt];
            out_vld <= 1'b1;
            out_lst <= k_sw_lst[gnt];
            lane    <= '0;
        end else if (out_vld && sm_rdy) begin
            lane <= lane + 1'b1;
            if (lane == last_lane) begin
                out_vld <= 1'b0;
            end
        end
    end

    // msb lane goes out first
    always_ff @(posedge clk) begin
        if (take) begin
            shift_q <= k_sw_dat[gnt];
        end else if (out_vld && sm_rdy) begin
            shift_q <= shift_q << word_w;
        end
    end

    assign sm_vld = out_vld;
    assign sm_dat = shift_q[block_w-1 -: word_w];
    assign sm_lst = out_lst && (lane == last_lane);

endmodule

// ==== hdl/stream_dispatch_top.sv ====
// stream dispatcher top: routes framed input to transform kernels and returns results
`timescale 1ns/1ps

module stream_dispatch_top #(
    parameter int num_kernels = stream_dispatch_pkg::num_kernels_def
) (
    input  logic                        clk,
    input  logic                        rstn,
    // input word stream
    input  logic                        ss_vld,
    output logic                        ss_rdy,
    input  stream_dispatch_pkg::word_t  ss_dat,
    // output word stream
    output logic                        sm_vld,
    input  logic                        sm_rdy,
    output stream_dispatch_pkg::word_t  sm_dat,
    output logic                        sm_lst,
    // kernel load side
    output logic [num_kernels-1:0]      k_ld_vld,
    input  logic [num_kernels-1:0]      k_ld_rdy,
    output stream_dispatch_pkg::block_t k_ld_dat,
    output logic [num_kernels-1:0]      k_decode,
    output stream_dispatch_pkg::mode_t  k_mode [num_kernels],
    // kernel return side
    input  logic [num_kernels-1:0]      k_sw_vld,
    output logic [num_kernels-1:0]      k_sw_rdy,
    input  stream_dispatch_pkg::block_t k_sw_dat [num_kernels],
    input  logic [num_kernels-1:0]      k_sw_lst,
    // status
    input  logic                        ap_read,
    output logic [2*num_kernels-1:0]    ap_ctrl
);
    import stream_dispatch_pkg::*;

    localparam int sel_w = (num_kernels > 1) ? $clog2(num_kernels) : 1;

    logic                   hdr_stb;
    frame_hdr_t             hdr;
    logic [sel_w-1:0]       kernel_sel;
    logic [num_kernels-1:0] frame_done;

    block_stream_if #(.width(block_w)) blk_if ();

    frame_ingress #(.num_kernels(num_kernels)) u_frame_ingress (
        .clk        (clk),
        .rstn       (rstn),
        .ss_vld     (ss_vld),
        .ss_dat     (ss_dat),
        .ss_rdy     (ss_rdy),
        .hdr_stb    (hdr_stb),
        .hdr        (hdr),
        .kernel_sel (kernel_sel),
        .blk        (blk_if.source)
    );

    kernel_router #(.num_kernels(num_kernels)) u_kernel_router (
        .clk        (clk),
        .rstn       (rstn),
        .hdr_stb    (hdr_stb),
        .hdr        (hdr),
        .kernel_sel (kernel_sel),
        .k_ld_rdy   (k_ld_rdy),
        .k_ld_vld   (k_ld_vld),
        .k_ld_dat   (k_ld_dat),
        .k_decode   (k_decode),
        .k_mode     (k_mode),
        .blk        (blk_if.sink)
    );

    kernel_status #(.num_kernels(num_kernels)) u_kernel_status (
        .clk        (clk),
        .rstn       (rstn),
        .k_decode   (k_decode),
        .frame_done (frame_done),
        .ap_read    (ap_read),
        .ap_ctrl    (ap_ctrl)
    );

    result_serializer #(.num_kernels(num_kernels)) u_result_serializer (
        .clk        (clk),
        .rstn       (rstn),
        .k_sw_vld   (k_sw_vld),
        .k_sw_dat   (k_sw_dat),
        .k_sw_lst   (k_sw_lst),
        .k_sw_rdy   (k_sw_rdy),
        .sm_rdy     (sm_rdy),
        .sm_vld     (sm_vld),
        .sm_dat     (sm_dat),
        .sm_lst     (sm_lst),
        .frame_done (frame_done)
    );

endmodule

// ==== verification/stream_dispatch_properties.sv ====
// dispatcher properties: kernel load hold, decode pulse shape, output stability and back-pressure
`timescale 1ns/1ps

module stream_dispatch_properties #(
    parameter int num_kernels = stream_dispatch_pkg::num_kernels_def
) (
    input logic                        clk,
    input logic                        rstn,
    input logic [num_kernels-1:0]      k_ld_vld,
    input logic [num_kernels-1:0]      k_ld_rdy,
    input stream_dispatch_pkg::block_t k_ld_dat,
    input logic [num_kernels-1:0]      k_decode,
    input logic                        sm_vld,
    input logic                        sm_rdy,
    input stream_dispatch_pkg::word_t  sm_dat,
    input logic                        sm_lst,
    input logic                        ss_rdy,
    input logic                        blk_vld,
    input logic                        blk_rdy
);

    // assertion failures so far
    int fail_cnt = 0;

    // stalled kernel load keeps its target and data
    a_ld_hold: assert property (@(posedge clk) disable iff (!rstn)
        |(k_ld_vld & ~k_ld_rdy) |=> k_ld_vld == $past(k_ld_vld) && $stable(k_ld_dat))
        else begin
            $error("kernel load changed while stalled");
            fail_cnt++;
        end

    // decode is a single-cycle pulse ahead of any block of its frame
    a_dec_pulse: assert property (@(posedge clk) disable iff (!rstn)
        |k_decode |-> (k_ld_vld == '0) ##1 (k_decode == '0))
        else begin
            $error("decode pulse overlapped a load or lasted more than one cycle");
            fail_cnt++;
        end

    // stalled output word must hold
    a_sm_stable: assert property (@(posedge clk) disable iff (!rstn)
        sm_vld && !sm_rdy |=> sm_vld && $stable(sm_dat) && $stable(sm_lst))
        else begin
            $error("output word changed while stalled");
            fail_cnt++;
        end

    // input reopens the cycle after a packed block leaves
    a_back_pressure: assert property (@(posedge clk) disable iff (!rstn)
        blk_vld && blk_rdy |=> ss_rdy)
        else begin
            $error("input ready stayed low after a packed block left");
            fail_cnt++;
        end

endmodule

bind stream_dispatch_top stream_dispatch_properties #(.num_kernels(num_kernels)) u_props (
    .clk      (clk),
    .rstn     (rstn),
    .k_ld_vld (k_ld_vld),
    .k_ld_rdy (k_ld_rdy),
    .k_ld_dat (k_ld_dat),
    .k_decode (k_decode),
    .sm_vld   (sm_vld),
    .sm_rdy   (sm_rdy),
    .sm_dat   (sm_dat),
    .sm_lst   (sm_lst),
    .ss_rdy   (ss_rdy),
    .blk_vld  (blk_if.vld),
    .blk_rdy  (blk_if.rdy)
);

// ==== verification/tb_stream_dispatch.sv ====
// stream dispatcher testbench: random frames, kernel models and scoreboard
`timescale 1ns/1ps

module tb_stream_dispatch;
    import stream_dispatch_pkg::*;

    localparam int nk         = num_kernels_def;
    localparam int n_frames   = 40;
    localparam int clk_per    = 8;
    localparam int timeout_ns = n_frames * 4 * 40 * clk_per;

    logic            clk;
    logic            rstn;
    logic            ss_vld;
    logic            ss_rdy;
    word_t           ss_dat;
    logic            sm_vld;
    logic            sm_rdy;
    word_t           sm_dat;
    logic            sm_lst;
    logic [nk-1:0]   k_ld_vld;
    logic [nk-1:0]   k_ld_rdy;
    block_t          k_ld_dat;
    logic [nk-1:0]   k_decode;
    mode_t           k_mode [nk];
    logic [nk-1:0]   k_sw_vld;
    logic [nk-1:0]   k_sw_rdy;
    block_t          k_sw_dat [nk];
    logic [nk-1:0]   k_sw_lst;
    logic            ap_read;
    logic [2*nk-1:0] ap_ctrl;

    // stimulus and reference model state
    word_t         ss_q [$];
    block_t        exp_ld [nk][$];
    mode_t         exp_mode [nk][$];
    int            exp_len [nk][$];
    block_t        frm_buf [nk][$];
    block_t        ret_q [nk][$];
    bit            ret_lst_q [nk][$];
    word_t         exp_out [$];
    bit            exp_out_lst [$];
    int            ld_left [nk];
    mode_t         cur_mode [nk];
    logic [nk-1:0] idle_m;
    logic [nk-1:0] done_m;
    bit            locked;
    int            lock_k;
    bit            ss_moved;
    bit            quiet;
    int            quiet_left;

    stream_dispatch_top #(.num_kernels(nk)) u_stream_dispatch_top (
        .clk      (clk),
        .rstn     (rstn),
        .ss_vld   (ss_vld),
        .ss_rdy   (ss_rdy),
        .ss_dat   (ss_dat),
        .sm_vld   (sm_vld),
        .sm_rdy   (sm_rdy),
        .sm_dat   (sm_dat),
        .sm_lst   (sm_lst),
        .k_ld_vld (k_ld_vld),
        .k_ld_rdy (k_ld_rdy),
        .k_ld_dat (k_ld_dat),
        .k_decode (k_decode),
        .k_mode   (k_mode),
        .k_sw_vld (k_sw_vld),
        .k_sw_rdy (k_sw_rdy),
        .k_sw_dat (k_sw_dat),
        .k_sw_lst (k_sw_lst),
        .ap_read  (ap_read),
        .ap_ctrl  (ap_ctrl)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_per / 2) clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_block(input string name, input block_t got, input block_t want);
        if (got !== want) begin
            abort_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, want));
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t want);
        if (got !== want) begin
            abort_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, want));
        end
    endtask

    task automatic check_mode(input string name, input mode_t got, input mode_t want);
        if (got !== want) begin
            abort_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, want));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        if (got !== want) begin
            abort_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, want));
        end
    endtask

    task automatic check_status(input string name, input logic [2*nk-1:0] got,
                                input logic [2*nk-1:0] want);
        if (got !== want) begin
            abort_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, want));
        end
    endtask

    // random frames with some aimed outside the kernel range
    task automatic build_frames();
        dst_t  d;
        mode_t m;
        len_t  n;
        word_t w [words_per_block];
        int    k;
        for (int f = 0; f < n_frames; f++) begin
            d = dst_t'(32'h02 + $urandom % 8);
            m = mode_t'(1 + $urandom % 4);
            n = len_t'(1 + $urandom % 4);
            k = int'(d) - int'(kernel_dst_base);
            ss_q.push_back({d, m, n});
            if (k >= 0 && k < nk) begin
                exp_mode[k].push_back(m);
                exp_len[k].push_back(int'(n));
            end
            for (int b = 0; b < int'(n); b++) begin
                for (int j = 0; j < words_per_block; j++) begin
                    w[j] = $urandom;
                    ss_q.push_back(w[j]);
                end
                if (k >= 0 && k < nk) begin
                    exp_ld[k].push_back({w[0], w[1], w[2], w[3]});
                end
            end
        end
    endtask

    function automatic logic [2*nk-1:0] model_ctrl();
        for (int i = 0; i < nk; i++) begin
            model_ctrl[2*i+1] = idle_m[i];
            model_ctrl[2*i]   = done_m[i];
        end
    endfunction

    function automatic bit drained();
        drained = (ss_q.size() == 0) && (exp_out.size() == 0) && !ss_vld;
        for (int i = 0; i < nk; i++) begin
            if (exp_ld[i].size() != 0 || exp_mode[i].size() != 0 || ret_q[i].size() != 0) begin
                drained = 1'b0;
            end
        end
    endfunction

    // kernel load side returns each finished frame with the mode xored in
    task automatic collect_loads();
        block_t e;
        for (int i = 0; i < nk; i++) begin
            if (k_ld_vld[i] && k_ld_rdy[i]) begin
                if (ld_left[i] == 0 || exp_ld[i].size() == 0) begin
                    abort_run($sformatf("kernel %0d got a block outside a decoded frame", i));
                end else begin
                    e = exp_ld[i].pop_front();
                    check_mode($sformatf("k_mode[%0d]", i), k_mode[i], cur_mode[i]);
                    check_block($sformatf("k_ld_dat[%0d]", i), k_ld_dat, e);
                    frm_buf[i].push_back(e ^ {(block_w / 8){cur_mode[i]}});
                    ld_left[i]--;
                    while (ld_left[i] == 0 && frm_buf[i].size() > 0) begin
                        ret_q[i].push_back(frm_buf[i].pop_front());
                        ret_lst_q[i].push_back(frm_buf[i].size() == 0);
                    end
                end
            end
        end
    endtask

    task automatic apply_decodes();
        for (int i = 0; i < nk; i++) begin
            if (k_decode[i]) begin
                if (exp_mode[i].size() == 0 || ld_left[i] != 0) begin
                    abort_run($sformatf("unexpected decode pulse on kernel %0d", i));
                end else begin
                    cur_mode[i] = exp_mode[i].pop_front();
                    ld_left[i]  = exp_len[i].pop_front();
                    check_mode($sformatf("k_mode[%0d]", i), k_mode[i], cur_mode[i]);
                end
            end
        end
    endtask

    // status registers lag their events by one edge
    task automatic track_status();
        bit fd;
        check_status("ap_ctrl", ap_ctrl, model_ctrl());
        for (int i = 0; i < nk; i++) begin
            fd = k_sw_vld[i] && k_sw_rdy[i] && k_sw_lst[i];
            if (k_decode[i]) begin
                idle_m[i] = 1'b0;
            end else if (fd) begin
                idle_m[i] = 1'b1;
            end
            if (fd) begin
                done_m[i] = 1'b1;
            end else if (ap_read) begin
                done_m[i] = 1'b0;
            end
        end
    endtask

    task automatic take_results();
        block_t b;
        bit     l;
        int     low;
        low = -1;
        for (int i = nk - 1; i >= 0; i--) begin
            if (k_sw_vld[i]) begin
                low = i;
            end
        end
        for (int i = 0; i < nk; i++) begin
            if (k_sw_vld[i] && k_sw_rdy[i]) begin
                if ((locked && i != lock_k) || (!locked && i != low)) begin
                    abort_run($sformatf("result from kernel %0d taken out of turn", i));
                end else begin
                    b = ret_q[i].pop_front();
                    l = ret_lst_q[i].pop_front();
                    for (int j = 0; j < words_per_block; j++) begin
                        exp_out.push_back(b[block_w-1-word_w*j -: word_w]);
                        exp_out_lst.push_back(l && j == words_per_block - 1);
                    end
                    locked = !l;
                    lock_k = i;
                end
            end
        end
    endtask

    task automatic score_streams();
        ss_moved = ss_vld && ss_rdy;
        if (ss_moved) begin
            void'(ss_q.pop_front());
        end
        if (sm_vld && sm_rdy) begin
            if (exp_out.size() == 0) begin
                abort_run("output word appeared with no result pending");
            end else begin
                check_word("sm_dat", sm_dat, exp_out.pop_front());
                check_flag("sm_lst", sm_lst, exp_out_lst.pop_front());
            end
        end
        if (u_stream_dispatch_top.u_props.fail_cnt != 0) begin
            abort_run("a bound assertion on the DUT failed");
        end
    endtask

    task automatic drive_inputs();
        if (ss_moved || !ss_vld) begin
            ss_vld = (ss_q.size() > 0) && ($urandom % 4 != 0);
            if (ss_vld) begin
                ss_dat = ss_q[0];
            end
        end
        k_ld_rdy = nk'($urandom);
        sm_rdy   = ($urandom % 2) == 1;
        ap_read  = !quiet && ($urandom % 8 == 0);
        // kernel models hold valid until their block is taken
        for (int i = 0; i < nk; i++) begin
            k_sw_vld[i] = ret_q[i].size() > 0;
            k_sw_dat[i] = '0;
            k_sw_lst[i] = 1'b0;
            if (k_sw_vld[i]) begin
                k_sw_dat[i] = ret_q[i][0];
                k_sw_lst[i] = ret_lst_q[i][0];
            end
        end
    endtask

    initial begin
        #(timeout_ns);
        abort_run("run timed out before every frame came back");
    end

    initial begin
        rstn       = 1'b0;
        ss_vld     = 1'b0;
        ss_dat     = '0;
        sm_rdy     = 1'b0;
        k_ld_rdy   = '0;
        k_sw_vld   = '0;
        k_sw_lst   = '0;
        ap_read    = 1'b0;
        idle_m     = '1;
        done_m     = '0;
        locked     = 1'b0;
        lock_k     = 0;
        ss_moved   = 1'b0;
        quiet      = 1'b0;
        quiet_left = 4;
        for (int i = 0; i < nk; i++) begin
            k_sw_dat[i] = '0;
            ld_left[i]  = 0;
            cur_mode[i] = '0;
        end
        void'($urandom(32'h937));
        build_frames();
        repeat (3) @(posedge clk);
        #1 rstn = 1'b1;
        while (quiet_left > 0) begin
            @(posedge clk);
            collect_loads();
            apply_decodes();
            track_status();
            take_results();
            score_streams();
            #1;
            drive_inputs();
            if (drained()) begin
                quiet = 1'b1;
                quiet_left--;
            end
        end
        // every kernel back to idle at the quiet point
        check_status("ap_ctrl", ap_ctrl, model_ctrl());
        if (idle_m != '1) begin
            abort_run("a kernel was still busy after all frames returned");
        end
        if (u_stream_dispatch_top.u_props.fail_cnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== files.f ====
hdl/stream_dispatch_pkg.sv
hdl/block_stream_if.sv
hdl/frame_ingress.sv
hdl/kernel_router.sv
hdl/kernel_status.sv
hdl/result_serializer.sv
hdl/stream_dispatch_top.sv
verification/stream_dispatch_properties.sv
verification/tb_stream_dispatch.sv
